/* source/backend_config.svh */
`ifndef BACKEND_CONFIG_SVH
`define BACKEND_CONFIG_SVH

// datapath width for the rv32i back end
`define BACKEND_XLEN 32

// addi x0, x0, 0
`define BACKEND_NOP 32'h0000_0013

// data memory depth in 32-bit words
`define BACKEND_DMEM_WORDS 256

`endif

/* source/backend_pkg.sv */
`include "backend_config.svh"

package backend_pkg;

    // register file write data source
    typedef enum logic [2:0] {
        wb_alu       = 3'd0,
        wb_load      = 3'd1,
        wb_pc_plus_4 = 3'd2,
        wb_imm       = 3'd3,
        wb_csr       = 3'd4
    } wb_select_e;

    // bundle held in the ex/mem register
    typedef struct packed {
        logic [`BACKEND_XLEN-1:0] pc;
        logic [`BACKEND_XLEN-1:0] pc_plus_4;
        logic [31:0]              instruction;
        wb_select_e               wb_select;
        logic [`BACKEND_XLEN-1:0] imm;
        logic [`BACKEND_XLEN-1:0] alu_result;
        logic [`BACKEND_XLEN-1:0] store_data;
        logic [`BACKEND_XLEN-1:0] csr_read_data;
        logic                     reg_write;
        logic                     csr_write;
        logic                     mem_read;
        logic                     mem_write;
        logic [2:0]               funct3;
        logic [4:0]               rs1;
        logic [4:0]               rd;
        logic [6:0]               opcode;
    } ex_mem_t;

    // bundle held in the mem/wb register
    typedef struct packed {
        logic [`BACKEND_XLEN-1:0] pc;
        logic [`BACKEND_XLEN-1:0] pc_plus_4;
        logic [31:0]              instruction;
        wb_select_e               wb_select;
        logic [`BACKEND_XLEN-1:0] imm;
        logic [`BACKEND_XLEN-1:0] csr_read_data;
        logic [`BACKEND_XLEN-1:0] alu_result;
        logic                     reg_write;
        logic                     csr_write;
        logic [4:0]               rs1;
        logic [4:0]               rd;
        logic [6:0]               opcode;
        // extracted and extended load value
        logic [`BACKEND_XLEN-1:0] load_data;
    } mem_wb_t;

    typedef struct packed {
        logic                     enable;
        logic [4:0]               rd;
        logic [`BACKEND_XLEN-1:0] data;
    } rf_write_t;

    typedef struct packed {
        logic                     enable;
        logic [11:0]              addr;
        logic [`BACKEND_XLEN-1:0] data;
    } csr_write_t;

    // bubbles carry a nop and no write enables
    localparam ex_mem_t ex_mem_bubble = '{
        instruction: `BACKEND_NOP,
        wb_select:   wb_alu,
        default:     '0
    };

    localparam mem_wb_t mem_wb_bubble = '{
        instruction: `BACKEND_NOP,
        wb_select:   wb_alu,
        default:     '0
    };

endpackage

/* source/pipe_stage_reg.sv */
module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     clk_enable,
    input  logic     stall,
    input  logic     flush,
    input  payload_t bubble,
    input  payload_t d,
    output payload_t q
);

    // flush wins over stall, both only act on enabled edges
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= bubble;
        end else if (clk_enable) begin
            if (flush) begin
                q <= bubble;
            end else if (!stall) begin
                q <= d;
            end
        end
    end

    // stage contents are always defined once out of reset
    a_q_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(q)
    ) else $error("pipe_stage_reg: q holds unknown bits");

endmodule

/* source/load_store_align.sv */
`include "backend_config.svh"

module load_store_align (
    input  backend_pkg::ex_mem_t     ex,
    input  logic [`BACKEND_XLEN-1:0] read_word,
    output logic [7:0]               word_addr,
    output logic [3:0]               byte_enable,
    output logic [`BACKEND_XLEN-1:0] write_word,
    output backend_pkg::mem_wb_t     mem_wb
);

    logic [1:0]               offset;
    logic [`BACKEND_XLEN-1:0] shifted;
    logic [7:0]               byte_sel;
    logic [15:0]              half_sel;
    logic                     is_unsigned;
    logic [`BACKEND_XLEN-1:0] load_data;

    assign offset    = ex.alu_result[1:0];
    assign word_addr = ex.alu_result[9:2];

    // funct3[1:0] gives the access size, funct3[2] marks lbu/lhu
    assign is_unsigned = ex.funct3[2];

    // store lanes
    always_comb begin
        byte_enable = 4'b0000;
        write_word  = ex.store_data;
        if (ex.mem_write) begin
            case (ex.funct3[1:0])
                2'b00: begin
                    byte_enable = 4'b0001 << offset;
                    write_word  = {4{ex.store_data[7:0]}};
                end
                2'b01: begin
                    byte_enable = offset[1] ? 4'b1100 : 4'b0011;
                    write_word  = {2{ex.store_data[15:0]}};
                end
                default: begin
                    byte_enable = 4'b1111;
                    write_word  = ex.store_data;
                end
            endcase
        end
    end

    // load extraction
    assign shifted  = read_word >> {offset, 3'b000};
    assign byte_sel = shifted[7:0];
    assign half_sel = offset[1] ? read_word[31:16] : read_word[15:0];

    always_comb begin
        load_data = '0;
        if (ex.mem_read) begin
            case (ex.funct3[1:0])
                2'b00: begin
                    load_data = {{(`BACKEND_XLEN-8){byte_sel[7] & ~is_unsigned}}, byte_sel};
                end
                2'b01: begin
                    load_data = {{(`BACKEND_XLEN-16){half_sel[15] & ~is_unsigned}}, half_sel};
                end
                default: begin
                    load_data = read_word;
                end
            endcase
        end
    end

    always_comb begin
        mem_wb               = '0;
        mem_wb.pc            = ex.pc;
        mem_wb.pc_plus_4     = ex.pc_plus_4;
        mem_wb.instruction   = ex.instruction;
        mem_wb.wb_select     = ex.wb_select;
        mem_wb.imm           = ex.imm;
        mem_wb.csr_read_data = ex.csr_read_data;
        mem_wb.alu_result    = ex.alu_result;
        mem_wb.reg_write     = ex.reg_write;
        mem_wb.csr_write     = ex.csr_write;
        mem_wb.rs1           = ex.rs1;
        mem_wb.rd            = ex.rd;
        mem_wb.opcode        = ex.opcode;
        mem_wb.load_data     = load_data;
    end

    // no misaligned trap exists, so the execute stage must never send one
    always_comb begin
        if (ex.mem_read || ex.mem_write) begin
            assert (!(ex.mem_read && ex.mem_write))
                else $error("load_store_align: load and store in one bundle");
            assert (ex.funct3[1:0] != 2'b01 || !offset[0])
                else $error("load_store_align: halfword access not aligned");
            assert (ex.funct3[1:0] != 2'b10 || offset == 2'b00)
                else $error("load_store_align: word access not aligned");
        end
    end

endmodule

/* source/data_memory.sv */
`include "backend_config.svh"

module data_memory (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     clk_enable,
    input  logic                     stall,
    input  logic                     flush,
    input  logic                     mem_write,
    input  logic [7:0]               word_addr,
    input  logic [3:0]               byte_enable,
    input  logic [`BACKEND_XLEN-1:0] write_word,
    output logic [`BACKEND_XLEN-1:0] read_word
);

    logic [`BACKEND_XLEN-1:0] mem [`BACKEND_DMEM_WORDS];
    logic                     write_strobe;

    // a store only commits on an edge that also advances the pipeline
    assign write_strobe = clk_enable && !stall && !flush && mem_write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `BACKEND_DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (write_strobe) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_enable[b]) begin
                    mem[word_addr][b*8 +: 8] <= write_word[b*8 +: 8];
                end
            end
        end
    end

    // asynchronous read, so a load right behind a store sees its data
    assign read_word = mem[word_addr];

    // a committed store always carries at least one lane
    a_store_lanes: assert property (
        @(posedge clk) disable iff (reset)
        write_strobe |-> byte_enable != 4'b0000
    ) else $error("data_memory: store with no byte enables");

endmodule

/* source/writeback_unit.sv */
`include "backend_config.svh"

module writeback_unit (
    input  backend_pkg::mem_wb_t    wb,
    output backend_pkg::rf_write_t  rf_write,
    output backend_pkg::csr_write_t csr_write
);

    logic [`BACKEND_XLEN-1:0] wb_data;

    always_comb begin
        case (wb.wb_select)
            backend_pkg::wb_alu:       wb_data = wb.alu_result;
            backend_pkg::wb_load:      wb_data = wb.load_data;
            backend_pkg::wb_pc_plus_4: wb_data = wb.pc_plus_4;
            backend_pkg::wb_imm:       wb_data = wb.imm;
            backend_pkg::wb_csr:       wb_data = wb.csr_read_data;
            default:                   wb_data = wb.alu_result;
        endcase
    end

    // x0 is hardwired, writes to it are dropped here
    assign rf_write.enable = wb.reg_write && (wb.rd != 5'd0);
    assign rf_write.rd     = wb.rd;
    assign rf_write.data   = wb_data;

    // csr address sits in the i-type immediate field
    assign csr_write.enable = wb.csr_write;
    assign csr_write.addr   = wb.instruction[31:20];
    assign csr_write.data   = wb.alu_result;

endmodule

/* source/memory_backend_top.sv */
module memory_backend_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clk_enable,
    input  logic                    stall,
    input  logic                    flush,
    input  backend_pkg::ex_mem_t    ex_in,
    output backend_pkg::rf_write_t  rf_write,
    output backend_pkg::csr_write_t csr_write,
    output backend_pkg::mem_wb_t    wb_stage
);

    backend_pkg::ex_mem_t ex_mem_q;
    backend_pkg::mem_wb_t mem_wb_d;
    backend_pkg::mem_wb_t mem_wb_q;

    logic [7:0]  word_addr;
    logic [3:0]  byte_enable;
    logic [31:0] write_word;
    logic [31:0] read_word;

    // ex/mem register
    pipe_stage_reg #(
        .payload_t (backend_pkg::ex_mem_t)
    ) u_ex_mem (
        .clk        (clk),
        .reset      (reset),
        .clk_enable (clk_enable),
        .stall      (stall),
        .flush      (flush),
        .bubble     (backend_pkg::ex_mem_bubble),
        .d          (ex_in),
        .q          (ex_mem_q)
    );

    // memory stage
    load_store_align u_align (
        .ex          (ex_mem_q),
        .read_word   (read_word),
        .word_addr   (word_addr),
        .byte_enable (byte_enable),
        .write_word  (write_word),
        .mem_wb      (mem_wb_d)
    );

    data_memory u_dmem (
        .clk         (clk),
        .reset       (reset),
        .clk_enable  (clk_enable),
        .stall       (stall),
        .flush       (flush),
        .mem_write   (ex_mem_q.mem_write),
        .word_addr   (word_addr),
        .byte_enable (byte_enable),
        .write_word  (write_word),
        .read_word   (read_word)
    );

    // mem/wb register
    pipe_stage_reg #(
        .payload_t (backend_pkg::mem_wb_t)
    ) u_mem_wb (
        .clk        (clk),
        .reset      (reset),
        .clk_enable (clk_enable),
        .stall      (stall),
        .flush      (flush),
        .bubble     (backend_pkg::mem_wb_bubble),
        .d          (mem_wb_d),
        .q          (mem_wb_q)
    );

    // writeback stage
    writeback_unit u_wb (
        .wb        (mem_wb_q),
        .rf_write  (rf_write),
        .csr_write (csr_write)
    );

    assign wb_stage = mem_wb_q;

endmodule

/* sim/tb_memory_backend.sv */
`include "backend_config.svh"

module tb_memory_backend;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_tests = 64;

    typedef struct packed {
        backend_pkg::rf_write_t  rf;
        backend_pkg::csr_write_t csr;
    } expect_t;

    logic                    clk;
    logic                    reset;
    logic                    clk_enable;
    logic                    stall;
    logic                    flush;
    backend_pkg::ex_mem_t    ex_in;
    backend_pkg::rf_write_t  rf_write;
    backend_pkg::csr_write_t csr_write;
    backend_pkg::mem_wb_t    wb_stage;

    // trace columns, one entry per test
    logic [127:0] test_name [max_tests];
    logic [3:0]   hold_kind [max_tests];
    logic [3:0]   hold_n    [max_tests];
    logic         rnd       [max_tests];
    logic [2:0]   sel       [max_tests];
    logic [2:0]   f3        [max_tests];
    logic [4:0]   rd        [max_tests];
    logic         mr        [max_tests];
    logic         mw        [max_tests];
    logic         rw        [max_tests];
    logic         cw        [max_tests];
    logic [31:0]  val_a     [max_tests];
    logic [31:0]  val_b     [max_tests];
    logic [11:0]  csr_addr  [max_tests];
    logic         e_en      [max_tests];
    logic [4:0]   e_rd      [max_tests];
    logic [31:0]  e_data    [max_tests];
    logic         e_csr_en  [max_tests];
    logic [31:0]  e_csr_data[max_tests];

    int      num_tests;
    int      pass_count;
    int      fail_count;
    int      cycle_count;
    int      cycle_limit;
    integer  seed;
    logic    trace_ok;
    expect_t exp_q[$];

    memory_backend_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .clk_enable (clk_enable),
        .stall      (stall),
        .flush      (flush),
        .ex_in      (ex_in),
        .rf_write   (rf_write),
        .csr_write  (csr_write),
        .wb_stage   (wb_stage)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // cycle watchdog, armed once the trace length is known
    initial begin
        while (cycle_limit == 0 || cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: run exceeded %0d cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic load_trace(output logic opened);
        integer fd;
        integer code;
        string  line;
        opened = 1'b0;
        fd = $fopen("sim/memory_backend_trace.txt", "r");
        if (fd != 0) begin
            opened = 1'b1;
            while (!$feof(fd) && num_tests < max_tests) begin
                code = $fgets(line, fd);
                if (code == 0 || line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                code = $sscanf(line,
                    "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    test_name[num_tests], hold_kind[num_tests], hold_n[num_tests],
                    rnd[num_tests], sel[num_tests], f3[num_tests], rd[num_tests],
                    mr[num_tests], mw[num_tests], rw[num_tests], cw[num_tests],
                    val_a[num_tests], val_b[num_tests], csr_addr[num_tests],
                    e_en[num_tests], e_rd[num_tests], e_data[num_tests],
                    e_csr_en[num_tests], e_csr_data[num_tests]);
                if (code == 19) begin
                    num_tests = num_tests + 1;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic make_bundle(input int i, output backend_pkg::ex_mem_t bundle);
        bundle               = backend_pkg::ex_mem_bubble;
        bundle.wb_select     = backend_pkg::wb_select_e'(sel[i]);
        bundle.funct3        = f3[i];
        bundle.rd            = rd[i];
        bundle.mem_read      = mr[i];
        bundle.mem_write     = mw[i];
        bundle.reg_write     = rw[i];
        bundle.csr_write     = cw[i];
        bundle.alu_result    = val_a[i];
        // only the selected source carries the second operand
        bundle.imm           = (sel[i] == 3'd3) ? val_b[i] : ~val_b[i];
        bundle.pc_plus_4     = (sel[i] == 3'd2) ? val_b[i] : ~val_b[i];
        bundle.pc            = bundle.pc_plus_4 - 32'd4;
        bundle.csr_read_data = (sel[i] == 3'd4) ? val_b[i] : ~val_b[i];
        bundle.store_data    = val_b[i];
        // csrrw with the csr number in the immediate field
        bundle.instruction   = cw[i] ? {csr_addr[i], 20'h01073} : `BACKEND_NOP;
        bundle.opcode        = bundle.instruction[6:0];
    endtask

    function automatic expect_t masked(input expect_t v);
        expect_t m;
        m = v;
        if (!m.rf.enable) begin
            m.rf.rd   = '0;
            m.rf.data = '0;
        end
        if (!m.csr.enable) begin
            m.csr.addr = '0;
            m.csr.data = '0;
        end
        return m;
    endfunction

    task automatic run_test(input int i);
        backend_pkg::ex_mem_t bundle;
        expect_t              exp;
        expect_t              act;
        logic                 ok;
        ok = 1'b1;
        if (rnd[i]) begin
            val_a[i]  = $random(seed);
            val_b[i]  = $random(seed);
            e_data[i] = (sel[i] == 3'd3) ? val_b[i] : val_a[i];
        end
        make_bundle(i, bundle);
        exp.rf.enable  = e_en[i];
        exp.rf.rd      = e_rd[i];
        exp.rf.data    = e_data[i];
        exp.csr.enable = e_csr_en[i];
        exp.csr.addr   = csr_addr[i];
        exp.csr.data   = e_csr_data[i];
        exp_q.push_back(exp);
        ex_in = bundle;
        tick();
        ex_in = backend_pkg::ex_mem_bubble;
        for (int k = 0; k < int'(hold_n[i]) && hold_kind[i] != 4'd3; k++) begin
            stall      = (hold_kind[i] == 4'd1);
            clk_enable = (hold_kind[i] != 4'd2);
            tick();
            if (rf_write.enable || csr_write.enable) begin
                $display("ERROR %0s held edge expected en 00 actual en %b%b",
                         test_name[i], rf_write.enable, csr_write.enable);
                ok = 1'b0;
            end
        end
        stall      = 1'b0;
        clk_enable = 1'b1;
        if (hold_kind[i] == 4'd3) begin
            // a younger bundle on the flushed edge is dropped as well
            ex_in = bundle;
            flush = 1'b1;
            tick();
            flush = 1'b0;
            ex_in = backend_pkg::ex_mem_bubble;
            // in-flight bundles became bubbles
            exp_q.delete();
            if (rf_write.enable || csr_write.enable ||
                wb_stage.instruction != `BACKEND_NOP) begin
                $display("ERROR %0s expected en 00 instr %h actual en %b%b instr %h",
                         test_name[i], `BACKEND_NOP, rf_write.enable,
                         csr_write.enable, wb_stage.instruction);
                ok = 1'b0;
            end
            tick();
            if (rf_write.enable || csr_write.enable) begin
                $display("ERROR %0s after flush expected en 00 actual en %b%b",
                         test_name[i], rf_write.enable, csr_write.enable);
                ok = 1'b0;
            end
        end else begin
            tick();
            if (exp_q.size() == 0) begin
                $display("%0s: no expected result was queued", test_name[i]);
                ok = 1'b0;
            end else begin
                exp = masked(exp_q.pop_front());
                act.rf  = rf_write;
                act.csr = csr_write;
                act     = masked(act);
                if (act != exp) begin
                    $display("ERROR %0s expected %h actual %h", test_name[i], exp, act);
                    ok = 1'b0;
                end
            end
        end
        if (ok) begin
            pass_count = pass_count + 1;
            $display("pass %0s", test_name[i]);
        end else begin
            fail_count = fail_count + 1;
            $display("fail %0s", test_name[i]);
        end
    endtask

    initial begin
        reset       = 1'b1;
        clk_enable  = 1'b1;
        stall       = 1'b0;
        flush       = 1'b0;
        ex_in       = backend_pkg::ex_mem_bubble;
        seed        = 32'hc225;
        num_tests   = 0;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        cycle_limit = 0;
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("could not open the trace file");
            $display("Simulation failed");
            $finish;
        end else begin
            cycle_limit = num_tests * 4 + 20;
            repeat (2) @(posedge clk);
            #1;
            reset = 1'b0;
            if (rf_write.enable || csr_write.enable ||
                wb_stage.instruction != `BACKEND_NOP) begin
                $display("ERROR reset_state expected en 00 instr %h actual en %b%b instr %h",
                         `BACKEND_NOP, rf_write.enable, csr_write.enable,
                         wb_stage.instruction);
                $display("fail reset_state");
                fail_count = fail_count + 1;
            end else begin
                $display("pass reset_state");
                pass_count = pass_count + 1;
            end
            for (int i = 0; i < num_tests; i++) begin
                run_test(i);
            end
            $display("tests passed %0d failed %0d", pass_count, fail_count);
            if (fail_count == 0 && num_tests > 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

/* sim/memory_backend_trace.txt */
# name hold_kind(1 stall,2 clk_enable low,3 flush) hold_n rnd sel funct3 rd mr mw rw cw
# a(alu_result) b(other sources) csr_addr exp_en exp_rd exp_data exp_csr_en exp_csr_data
alu_rand     0 0 1 0 0 03 0 0 1 0 00000000 00000000 000 1 03 00000000 0 00000000
imm_rand     0 0 1 3 0 04 0 0 1 0 00000000 00000000 000 1 04 00000000 0 00000000
pc_plus_4    0 0 0 2 0 01 0 0 1 0 00000010 00000104 000 1 01 00000104 0 00000000
csr_read     0 0 0 4 1 07 0 0 1 1 80000000 00000100 305 1 07 00000100 1 80000000
csr_rd_zero  0 0 0 4 1 00 0 0 1 1 0000abcd 00000011 340 0 00 00000000 1 0000abcd
alu_rd_zero  0 0 0 0 0 00 0 0 1 0 12345678 00000000 000 0 00 00000000 0 00000000
sw_word      0 0 0 0 2 00 0 1 0 0 00000100 8badf00d 000 0 00 00000000 0 00000000
lw_0         0 0 0 1 2 05 1 0 1 0 00000100 00000000 000 1 05 8badf00d 0 00000000
lb_0         0 0 0 1 0 05 1 0 1 0 00000100 00000000 000 1 05 0000000d 0 00000000
lb_1         0 0 0 1 0 05 1 0 1 0 00000101 00000000 000 1 05 fffffff0 0 00000000
lb_2         0 0 0 1 0 05 1 0 1 0 00000102 00000000 000 1 05 ffffffad 0 00000000
lb_3         0 0 0 1 0 05 1 0 1 0 00000103 00000000 000 1 05 ffffff8b 0 00000000
lbu_0        0 0 0 1 4 06 1 0 1 0 00000100 00000000 000 1 06 0000000d 0 00000000
lbu_1        0 0 0 1 4 06 1 0 1 0 00000101 00000000 000 1 06 000000f0 0 00000000
lbu_2        0 0 0 1 4 06 1 0 1 0 00000102 00000000 000 1 06 000000ad 0 00000000
lbu_3        0 0 0 1 4 06 1 0 1 0 00000103 00000000 000 1 06 0000008b 0 00000000
lh_0         0 0 0 1 1 08 1 0 1 0 00000100 00000000 000 1 08 fffff00d 0 00000000
lh_2         0 0 0 1 1 08 1 0 1 0 00000102 00000000 000 1 08 ffff8bad 0 00000000
lhu_0        0 0 0 1 5 08 1 0 1 0 00000100 00000000 000 1 08 0000f00d 0 00000000
lhu_2        0 0 0 1 5 08 1 0 1 0 00000102 00000000 000 1 08 00008bad 0 00000000
sb_byte      0 0 0 0 0 00 0 1 0 0 00000105 000000a7 000 0 00 00000000 0 00000000
lb_sb        0 0 0 1 0 09 1 0 1 0 00000105 00000000 000 1 09 ffffffa7 0 00000000
lbu_sb_next  0 0 0 1 4 09 1 0 1 0 00000104 00000000 000 1 09 00000000 0 00000000
lw_sb        0 0 0 1 2 09 1 0 1 0 00000104 00000000 000 1 09 0000a700 0 00000000
sh_half      0 0 0 0 1 00 0 1 0 0 0000010a 00001234 000 0 00 00000000 0 00000000
lh_sh        0 0 0 1 1 0a 1 0 1 0 0000010a 00000000 000 1 0a 00001234 0 00000000
lw_sh        0 0 0 1 2 0a 1 0 1 0 00000108 00000000 000 1 0a 12340000 0 00000000
stall_3      1 3 0 0 0 09 0 0 1 0 0000beef 00000000 000 1 09 0000beef 0 00000000
clk_en_low_2 2 2 0 3 0 0a 0 0 1 0 00000000 0000cafe 000 1 0a 0000cafe 0 00000000
flush_alu    3 1 0 0 0 0b 0 0 1 0 11111111 00000000 000 0 00 00000000 0 00000000
after_flush  0 0 0 0 0 0c 0 0 1 0 22222222 00000000 000 1 0c 22222222 0 00000000

/* src.f */
+incdir+source
source/backend_pkg.sv
source/pipe_stage_reg.sv
source/load_store_align.sv
source/data_memory.sv
source/writeback_unit.sv
source/memory_backend_top.sv
sim/tb_memory_backend.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f \
    --top-module tb_memory_backend -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" <<< "$output"; then
    exit 0
fi
exit 1
